// ==== logic/lsuPkg.sv ====
// lsuPkg shared widths and encodings for the uncached load/store unit
package lsuPkg;

  //////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////

  // data and address width, fixed for rv32
  localparam int xlen = 32;

  // memRW encoding, bit 1 is read and bit 0 is write
  typedef enum logic [1:0] {
    opNone  = 2'b00,
    opWrite = 2'b01,
    opRead  = 2'b10
  } memOp;

  // funct3 width codes for loads and stores
  // bit 2 set means zero extend on loads
  typedef enum logic [2:0] {
    byteSigned   = 3'b000,
    halfSigned   = 3'b001,
    word         = 3'b010,
    byteUnsigned = 3'b100,
    halfUnsigned = 3'b101
  } widthCode;

  // bus controller states
  typedef enum logic [1:0] {
    stIdle  = 2'b00,
    stFetch = 2'b01,
    stWrite = 2'b10,
    stDone  = 2'b11
  } busState;

endpackage

// ==== logic/memAccessCheck.sv ====
// memAccessCheck memory-stage address register and misalignment detection
module memAccessCheck (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    stall,
  input  logic [lsuPkg::xlen-1:0] adrE,
  input  logic [1:0]              memRW,
  input  logic [2:0]              funct3,
  output logic [lsuPkg::xlen-1:0] adrM,
  output lsuPkg::memOp            request,
  output logic                    loadMisalignedFault,
  output logic                    storeMisalignedFault
);

  logic misaligned;
  lsuPkg::memOp rawOp;

  // execute to memory address register, frozen while the pipe stalls
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      adrM <= '0;
    end else if (!stall) begin
      adrM <= adrE;
    end
  end

  // alignment depends only on the size bits of funct3
  always_comb begin
    case (funct3[1:0])
      2'b00:   misaligned = 1'b0;                // lb, lbu, sb
      2'b01:   misaligned = adrM[0];             // lh, lhu, sh
      2'b10:   misaligned = adrM[1] | adrM[0];   // lw, sw
      default: misaligned = 1'b1;                // no doubleword on rv32
    endcase
  end

  // decode memRW, both bits set is not a legal request
  always_comb begin
    case (memRW)
      2'b10:   rawOp = lsuPkg::opRead;
      2'b01:   rawOp = lsuPkg::opWrite;
      default: rawOp = lsuPkg::opNone;
    endcase
  end

  // faults go straight to the cpu in the request cycle
  assign loadMisalignedFault  = misaligned & memRW[1];
  assign storeMisalignedFault = misaligned & memRW[0];

  // a faulting access never reaches the bus controller
  assign request = misaligned ? lsuPkg::opNone : rawOp;

endmodule

// ==== logic/busFsm.sv ====
// busFsm bus sequencer for line fetches and single-word uncached stores
module busFsm #(
  parameter int wordsPerLine = 4
) (
  input  logic                            clk,
  input  logic                            rstN,
  input  lsuPkg::memOp                    request,
  input  logic [lsuPkg::xlen-1:0]         adrM,
  input  logic                            busAck,
  output logic                            busRead,
  output logic                            busWrite,
  output logic [lsuPkg::xlen-1:0]         busAdr,
  output logic [$clog2(wordsPerLine)-1:0] wordCount,
  output logic                            lsuStall,
  output logic                            capture
);

  localparam int logWpl     = $clog2(wordsPerLine);
  // byte offset bits within one line
  localparam int offsetBits = logWpl + 2;

  lsuPkg::busState state;
  lsuPkg::busState nextState;

  logic                    lastBeat;
  logic [lsuPkg::xlen-1:0] lineBase;
  logic [lsuPkg::xlen-1:0] fetchAdr;

  //////////////////////////////////////////////////
  // state register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= lsuPkg::stIdle;
    end else begin
      state <= nextState;
    end
  end

  // final beat of the line
  assign lastBeat = (wordCount == logWpl'(wordsPerLine - 1));

  always_comb begin
    nextState = state;
    case (state)
      lsuPkg::stIdle: begin
        if (request == lsuPkg::opRead) begin
          nextState = lsuPkg::stFetch;
        end else if (request == lsuPkg::opWrite) begin
          nextState = lsuPkg::stWrite;
        end
      end
      // wait states just hold here until the ack
      lsuPkg::stFetch: begin
        if (busAck && lastBeat) begin
          nextState = lsuPkg::stDone;
        end
      end
      lsuPkg::stWrite: begin
        if (busAck) begin
          nextState = lsuPkg::stDone;
        end
      end
      // one cycle for the cpu to advance, then back to idle
      // so a held request is not issued twice
      lsuPkg::stDone: nextState = lsuPkg::stIdle;
      default:        nextState = lsuPkg::stIdle;
    endcase
  end

  //////////////////////////////////////////////////
  // beat counter
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wordCount <= '0;
    end else if (capture) begin
      // wrap to zero for the next line
      wordCount <= lastBeat ? '0 : wordCount + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // bus outputs
  //////////////////////////////////////////////////

  assign busRead  = (state == lsuPkg::stFetch);
  assign busWrite = (state == lsuPkg::stWrite);

  // slot enable, each slot compares wordCount with its own index
  assign capture = busRead & busAck;

  // line base is adrM with the line offset cleared
  assign lineBase = {adrM[lsuPkg::xlen-1:offsetBits], {offsetBits{1'b0}}};
  // beat k sits at base + 4k
  assign fetchAdr = lineBase
                  + {{(lsuPkg::xlen - offsetBits){1'b0}}, wordCount, 2'b00};

  // stores go out at the unmodified address
  assign busAdr = busRead ? fetchAdr : adrM;

  // stall from the request cycle up to, not including, the done cycle
  assign lsuStall = (request != lsuPkg::opNone) && (state != lsuPkg::stDone);

endmodule

// ==== logic/fetchSlot.sv ====
// fetchSlot one word of the line fetch buffer with select gated output
module fetchSlot #(
  parameter int slotIndex    = 0,
  parameter int wordsPerLine = 4
) (
  input  logic                            clk,
  input  logic                            rstN,
  input  logic                            capture,
  input  logic [$clog2(wordsPerLine)-1:0] wordCount,
  input  logic [$clog2(wordsPerLine)-1:0] wordSel,
  input  logic [lsuPkg::xlen-1:0]         busRdata,
  output logic [lsuPkg::xlen-1:0]         slotWord
);

  localparam int logWpl = $clog2(wordsPerLine);

  logic [lsuPkg::xlen-1:0] stored;

  // grab the beat meant for this slot
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      stored <= '0;
    end else if (capture && (wordCount == logWpl'(slotIndex))) begin
      stored <= busRdata;
    end
  end

  // zero when unselected so the slots can be ORed together
  assign slotWord = (wordSel == logWpl'(slotIndex)) ? stored : '0;

endmodule

// ==== logic/subwordRead.sv ====
// subwordRead merges the fetch slots and extracts and extends the load data
module subwordRead #(
  parameter int wordsPerLine = 4
) (
  input  logic [wordsPerLine*lsuPkg::xlen-1:0] slotWords,
  input  logic [1:0]                           byteOffset,
  input  logic [2:0]                           funct3,
  output logic [lsuPkg::xlen-1:0]              readData
);

  logic [lsuPkg::xlen-1:0] wordData;
  logic [7:0]              byteData;
  logic [15:0]             halfData;

  // only the selected slot is nonzero
  always_comb begin
    wordData = '0;
    for (int i = 0; i < wordsPerLine; i++) begin
      wordData = wordData | slotWords[i*lsuPkg::xlen +: lsuPkg::xlen];
    end
  end

  // byte lane pick, little endian
  always_comb begin
    case (byteOffset)
      2'b00:   byteData = wordData[7:0];
      2'b01:   byteData = wordData[15:8];
      2'b10:   byteData = wordData[23:16];
      default: byteData = wordData[31:24];
    endcase
  end

  // halfwords are aligned, so bit 1 picks the half
  assign halfData = byteOffset[1] ? wordData[31:16] : wordData[15:0];

  //////////////////////////////////////////////////
  // extension
  //////////////////////////////////////////////////

  always_comb begin
    case (lsuPkg::widthCode'(funct3))
      lsuPkg::byteSigned:   readData = {{24{byteData[7]}}, byteData};
      lsuPkg::halfSigned:   readData = {{16{halfData[15]}}, halfData};
      lsuPkg::byteUnsigned: readData = {24'b0, byteData};
      lsuPkg::halfUnsigned: readData = {16'b0, halfData};
      // word and anything unlisted pass the whole word
      default:              readData = wordData;
    endcase
  end

endmodule

// ==== logic/subwordWrite.sv ====
// subwordWrite replicates store data across byte lanes and forms the bus size
module subwordWrite (
  input  logic [lsuPkg::xlen-1:0] writeData,
  input  logic [2:0]              funct3,
  output logic [lsuPkg::xlen-1:0] busWdata,
  output logic [1:0]              busSize
);

  // lane replication so the memory can take the byte lanes it needs
  always_comb begin
    case (lsuPkg::widthCode'(funct3))
      lsuPkg::byteSigned,
      lsuPkg::byteUnsigned: begin
        busWdata = {4{writeData[7:0]}};
      end
      lsuPkg::halfSigned,
      lsuPkg::halfUnsigned: begin
        busWdata = {2{writeData[15:0]}};
      end
      // full word unchanged
      default: begin
        busWdata = writeData;
      end
    endcase
  end

  // size is log2 of the byte count, 0 byte 1 half 2 word
  assign busSize = funct3[1:0];

endmodule

// ==== logic/lsu.sv ====
// lsu uncached load/store unit top level with line fetch buffer
module lsu #(
  parameter int wordsPerLine = 4
) (
  input  logic                    clk,
  input  logic                    rstN,
  // cpu side
  input  logic                    stall,
  input  logic [lsuPkg::xlen-1:0] adrE,
  input  logic [1:0]              memRW,
  input  logic [2:0]              funct3,
  input  logic [lsuPkg::xlen-1:0] writeData,
  output logic                    lsuStall,
  output logic [lsuPkg::xlen-1:0] readData,
  output logic                    loadMisalignedFault,
  output logic                    storeMisalignedFault,
  // bus side
  output logic [lsuPkg::xlen-1:0] busAdr,
  output logic                    busRead,
  output logic                    busWrite,
  input  logic                    busAck,
  input  logic [lsuPkg::xlen-1:0] busRdata,
  output logic [lsuPkg::xlen-1:0] busWdata,
  output logic [1:0]              busSize
);

  localparam int logWpl = $clog2(wordsPerLine);

  logic [lsuPkg::xlen-1:0]              adrM;
  lsuPkg::memOp                         request;
  logic [logWpl-1:0]                    wordCount;
  logic [logWpl-1:0]                    wordSel;
  logic                                 capture;
  logic [wordsPerLine*lsuPkg::xlen-1:0] slotWords;

  // adrM register lives in here, enabled by ~stall
  memAccessCheck accessCheck (.clk, .rstN, .stall, .adrE, .memRW, .funct3,
                              .adrM, .request, .loadMisalignedFault,
                              .storeMisalignedFault);

  busFsm #(.wordsPerLine(wordsPerLine)) busCtrl (
    .clk, .rstN, .request, .adrM, .busAck,
    .busRead, .busWrite, .busAdr, .wordCount, .lsuStall, .capture
  );

  //////////////////////////////////////////////////
  // fetch buffer
  //////////////////////////////////////////////////

  // word within the line that the load wants
  assign wordSel = adrM[logWpl+1:2];

  for (genvar i = 0; i < wordsPerLine; i++) begin : fetchBuffer
    fetchSlot #(.slotIndex(i), .wordsPerLine(wordsPerLine)) slot (
      .clk, .rstN, .capture, .wordCount, .wordSel, .busRdata,
      .slotWord(slotWords[i*lsuPkg::xlen +: lsuPkg::xlen])
    );
  end

  // drain side, valid in the done cycle
  subwordRead #(.wordsPerLine(wordsPerLine)) readPath (
    .slotWords, .byteOffset(adrM[1:0]), .funct3, .readData
  );

  // store path
  subwordWrite writePath (.writeData, .funct3, .busWdata, .busSize);

endmodule

// ==== test/clockGen.sv ====
// clockGen testbench clock source and power-on reset
module clockGen #(
  parameter int halfPeriod  = 20,
  parameter int resetCycles = 8
) (
  output logic clk,
  output logic rstN
);
  timeunit 1ns;
  timeprecision 1ps;

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #halfPeriod clk = ~clk;
    end
  end

  // reset held over the first rising edges, released on a falling edge
  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
  end

endmodule

// ==== test/lsuBus_props.sv ====
// lsuBusProps bus protocol properties for the bus sequencer
module lsuBusProps (
  input logic                    clk,
  input logic                    rstN,
  input lsuPkg::busState         state,
  input lsuPkg::memOp            request,
  input logic                    busRead,
  input logic                    busWrite,
  input logic                    busAck,
  input logic [lsuPkg::xlen-1:0] busAdr
);
  timeunit 1ns;
  timeprecision 1ps;

  // one strobe at a time
  strobesExclusive: assert property (@(posedge clk) disable iff (!rstN)
    !(busRead && busWrite))
    else $error("read and write strobes high together");

  // a beat still waiting for its ack keeps its address
  adrHeld: assert property (@(posedge clk) disable iff (!rstN)
    (busRead || busWrite) && !busAck |=> $stable(busAdr))
    else $error("busAdr moved during a wait state");

  // strobes stay quiet under reset
  quietInReset: assert property (@(posedge clk) !rstN |-> !busRead && !busWrite)
    else $error("bus strobe high during reset");

  // the matching request stays up for the whole transfer
  requestHeld: assert property (@(posedge clk) disable iff (!rstN)
    (state == lsuPkg::stFetch || state == lsuPkg::stWrite)
      |-> request == (state == lsuPkg::stFetch ? lsuPkg::opRead : lsuPkg::opWrite))
    else $error("request dropped before the transfer finished");

endmodule

// ==== test/lsuTb.sv ====
// lsuTb testbench running an operation table through the lsu against a bus memory model
module lsuTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int wordsPerLine = 4;
  localparam int maxOps       = 32;
  localparam int resetCycles  = 8;

  logic        clk;
  logic        rstN;
  logic        stall;
  logic [31:0] adrE;
  logic [1:0]  memRW;
  logic [2:0]  funct3;
  logic [31:0] writeData;
  logic        lsuStall;
  logic [31:0] readData;
  logic        loadMisalignedFault;
  logic        storeMisalignedFault;
  logic [31:0] busAdr;
  logic        busRead;
  logic        busWrite;
  logic        busAck;
  logic [31:0] busRdata;
  logic [31:0] busWdata;
  logic [1:0]  busSize;

  // five columns per operation
  logic [31:0] opTable [0:maxOps*5-1];
  logic [31:0] mem [0:255];
  logic [31:0] readBeats[$];
  // {size, address, data} per write beat
  logic [65:0] writeBeats[$];
  int          errors;
  int          checks;
  int          numOps;
  int          cycleCount;
  int          cycleLimit;
  int          ackDelay;

  clockGen #(.resetCycles(resetCycles)) clocks (.clk, .rstN);

  lsu #(.wordsPerLine(wordsPerLine)) uut (
    .clk, .rstN, .stall, .adrE, .memRW, .funct3, .writeData, .lsuStall, .readData,
    .loadMisalignedFault, .storeMisalignedFault, .busAdr, .busRead, .busWrite,
    .busAck, .busRdata, .busWdata, .busSize
  );

  bind busFsm lsuBusProps busProps (
    .clk, .rstN, .state, .request, .busRead, .busWrite, .busAck, .busAdr
  );

  // the cpu freezes its pipe exactly when the lsu asks
  assign stall = lsuStall;

  //////////////////////////////////////////////////
  // reference rules
  //////////////////////////////////////////////////

  // background pattern where every byte depends on the word address
  function automatic logic [31:0] fillWord(input logic [7:0] idx);
    return {idx ^ 8'hF0, idx, ~idx, idx ^ 8'h0F};
  endfunction

  // little endian extract with bit 2 of the code selecting zero extension
  function automatic logic [31:0] loadValue(input logic [31:0] w, input logic [1:0] ofs,
                                            input logic [2:0] code);
    logic [7:0]  b;
    logic [15:0] h;
    b = w[int'(ofs)*8 +: 8];
    h = ofs[1] ? w[31:16] : w[15:0];
    case (code[1:0])
      2'd0:    return code[2] ? {24'h0, b} : {{24{b[7]}}, b};
      2'd1:    return code[2] ? {16'h0, h} : {{16{h[15]}}, h};
      default: return w;
    endcase
  endfunction

  function automatic logic [31:0] laneData(input logic [31:0] d, input logic [2:0] code);
    case (code[1:0])
      2'd0:    return {4{d[7:0]}};
      2'd1:    return {2{d[15:0]}};
      default: return d;
    endcase
  endfunction

  function automatic bit misalignedAt(input logic [31:0] adr, input logic [2:0] code);
    return (code[1:0] == 2'd1 && adr[0]) || (code[1:0] == 2'd2 && adr[1:0] != 2'b00);
  endfunction

  // merge a write beat into the memory model by size and lane
  task automatic storeBeat(input logic [31:0] adr, input logic [31:0] d, input logic [1:0] size);
    for (int lane = 0; lane < 4; lane++) begin
      if (size == 2'd2 || (size == 2'd1 && lane[1] == adr[1])
          || (size == 2'd0 && lane == int'(adr[1:0]))) begin
        mem[adr[9:2]][lane*8 +: 8] = d[lane*8 +: 8];
      end
    end
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checks++;
    assert (actual === expected)
    else begin
      errors++;
      $display("error %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic checkFlag(input bit cond, input string what);
    checks++;
    assert (cond)
    else begin
      errors++;
      $display("%s", what);
    end
  endtask

  //////////////////////////////////////////////////
  // bus memory
  //////////////////////////////////////////////////

  // ack after 0 to 3 wait states and log each beat when its ack goes out
  always @(negedge clk) begin
    if (rstN && (busRead || busWrite) && ackDelay == 0) begin
      busAck = 1'b1;
      if (busRead) begin
        busRdata = mem[busAdr[9:2]];
        readBeats.push_back(busAdr);
      end else begin
        writeBeats.push_back({busSize, busAdr, busWdata});
        storeBeat(busAdr, busWdata, busSize);
      end
      ackDelay = int'($urandom % 4);
    end else begin
      busAck = 1'b0;
      if ((busRead || busWrite) && ackDelay > 0) begin
        ackDelay--;
      end
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("timeout after %0d cycles, the operation list did not finish", cycleLimit);
      $display("=== FAIL ===");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // operations
  //////////////////////////////////////////////////

  task automatic runOp(input int n);
    logic [31:0] kind;
    logic [2:0]  code;
    logic [31:0] adr;
    logic [31:0] data;
    logic [31:0] modelValue;
    logic [31:0] lineBase;
    logic [65:0] beat;
    string       name;
    kind = opTable[n*5];
    code = opTable[n*5+1][2:0];
    adr = opTable[n*5+2];
    data = opTable[n*5+3];
    name = $sformatf("op%0d", n);
    lineBase = adr & ~32'(wordsPerLine * 4 - 1);
    // address one cycle ahead of the request
    @(negedge clk);
    adrE = adr;
    @(negedge clk);
    readBeats.delete();
    writeBeats.delete();
    modelValue = loadValue(mem[adr[9:2]], adr[1:0], code);
    memRW = kind[1:0];
    funct3 = code;
    writeData = data;
    #1;
    if (misalignedAt(adr, code)) begin
      checkValue({name, " loadFault"}, {31'b0, kind == 32'd2}, {31'b0, loadMisalignedFault});
      checkValue({name, " storeFault"}, {31'b0, kind == 32'd1}, {31'b0, storeMisalignedFault});
      checkFlag(!lsuStall, {name, " misaligned access raised lsuStall"});
      @(negedge clk);
      checkFlag(readBeats.size() == 0 && writeBeats.size() == 0 && !busRead && !busWrite,
                {name, " misaligned access reached the bus"});
    end else begin
      checkFlag(lsuStall, {name, " lsuStall did not rise in the request cycle"});
      checkFlag(!loadMisalignedFault && !storeMisalignedFault, {name, " aligned access faulted"});
      // done cycle is the first one with lsuStall low
      do begin
        @(negedge clk);
      end while (lsuStall);
      checkFlag(!busRead && !busWrite, {name, " lsuStall fell with a bus beat still open"});
      if (kind[1]) begin
        checkValue({name, " readData vs file"}, opTable[n*5+4], readData);
        checkValue({name, " readData vs model"}, modelValue, readData);
        checkValue({name, " read beats"}, wordsPerLine, readBeats.size());
        for (int k = 0; k < readBeats.size(); k++) begin
          checkValue({name, " beat address"}, lineBase + 32'(4 * k), readBeats[k]);
        end
      end else begin
        checkValue({name, " write beats"}, 32'd1, writeBeats.size());
        if (writeBeats.size() > 0) begin
          beat = writeBeats[0];
          checkValue({name, " write address"}, adr, beat[63:32]);
          checkValue({name, " write data"}, laneData(data, code), beat[31:0]);
          checkValue({name, " write size"}, {30'b0, code[1:0]}, {30'b0, beat[65:64]});
        end
      end
    end
    memRW = 2'b00;
  endtask

  initial begin
    void'($urandom(78098));
    errors = 0;
    checks = 0;
    cycleCount = 0;
    ackDelay = 0;
    adrE = '0;
    memRW = 2'b00;
    funct3 = 3'b010;
    writeData = '0;
    busAck = 1'b0;
    busRdata = '0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = fillWord(i[7:0]);
    end
    // all ones marks the end of the table
    for (int i = 0; i < maxOps * 5; i++) begin
      opTable[i] = '1;
    end
    $readmemh("test/lsuInput.txt", opTable);
    numOps = 0;
    while (numOps < maxOps && opTable[numOps*5] !== 32'hFFFF_FFFF) begin
      numOps++;
    end
    cycleLimit = numOps * (wordsPerLine * 5 + 4) + resetCycles;
    checkFlag(numOps > 0, "operation table is empty or missing");
    wait (rstN === 1'b1);
    for (int n = 0; n < numOps; n++) begin
      runOp(n);
    end
    $display("%0d operations, %0d checks, %0d errors", numOps, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== test/lsuInput.txt ====
// kind (2 load, 1 store), width code, byte address, store data, expected load data
// expected is zero for stores and misaligned rows
2 2 00000010 00000000 F404FB0B
2 0 00000023 00000000 FFFFFFF8
2 4 00000023 00000000 000000F8
2 1 00000046 00000000 FFFFE111
2 5 00000044 00000000 0000EE1E
2 0 00000081 00000000 FFFFFFDF
2 0 00000082 00000000 00000020
2 1 00000100 00000000 FFFFBF4F
1 2 00000200 12345678 00000000
2 2 00000200 00000000 12345678
1 0 00000205 000000A7 00000000
2 0 00000205 00000000 FFFFFFA7
2 2 00000204 00000000 7181A78E
1 1 0000020A 0000BEEF 00000000
2 5 0000020A 00000000 0000BEEF
2 1 0000020A 00000000 FFFFBEEF
2 2 00000208 00000000 BEEF7D8D
2 2 00000301 00000000 00000000
2 1 00000103 00000000 00000000
1 2 00000302 11112222 00000000
1 1 00000105 00003333 00000000
2 2 000003FC 00000000 0FFF00F0

// ==== compile.f ====
logic/lsuPkg.sv
logic/memAccessCheck.sv
logic/busFsm.sv
logic/fetchSlot.sv
logic/subwordRead.sv
logic/subwordWrite.sv
logic/lsu.sv
test/clockGen.sv
test/lsuBus_props.sv
test/lsuTb.sv

// ==== Makefile ====
# Verilator build and run for the load/store unit testbench
VERILATOR ?= verilator
TOP       ?= lsuTb
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "^=== PASS ===$$"

clean:
	rm -rf $(OBJDIR)
